// File: hdl/wb_bridge_pkg.sv
/*
 * Sizes, bus structs and encodings shared by the AXI4-Lite to Wishbone chain
 * Wishbone addresses are word addresses, AXI addresses are byte addresses
 * Only single classic cycles are ever issued
 */
package wb_bridge_pkg;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////
	localparam int AXI_AW      = 12;
	localparam int DW          = 32;
	localparam int SW          = DW / 8;
	localparam int WB_AW       = AXI_AW - 2;
	localparam int REG_COUNT   = 64;
	localparam int REG_IDX_W   = 6;
	// Cycles of stb before the register slave answers, minus one
	localparam int WAIT_STATES = 2;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// Wishbone B4 cycle type identifiers
	typedef enum logic [2:0] {
		CTI_CLASSIC = 3'b000,
		CTI_CONST   = 3'b001,
		CTI_INCR    = 3'b010,
		CTI_END     = 3'b111
	} wbc_cti_e;

	////////////////////////////////////////
	// Bus structs
	////////////////////////////////////////
	// Pipelined master to slave
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] addr;
		logic [DW-1:0]    data;
		logic [SW-1:0]    sel;
	} wbp_req_t;

	// Pipelined slave to master
	typedef struct packed {
		logic          stall;
		logic          ack;
		logic          err;
		logic [DW-1:0] data;
	} wbp_rsp_t;

	// Classic master to slave
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] addr;
		logic [DW-1:0]    data;
		logic [SW-1:0]    sel;
		wbc_cti_e         cti;
		logic [1:0]       bte;
	} wbc_req_t;

	// Classic slave to master
	typedef struct packed {
		logic          ack;
		logic          err;
		logic [DW-1:0] data;
	} wbc_rsp_t;

endpackage

// File: hdl/axil2wbp.sv
/*
 * AXI4-Lite slave that turns each request into one Wishbone pipelined transaction
 * One transaction at a time, writes take priority over reads
 * AXI prot is accepted and ignored, the low two address bits are dropped
 */
`timescale 1ns/100ps

module axil2wbp (
	input  logic                                i_clk,
	input  logic                                i_reset,
	// Write address channel
	input  logic                                i_awvalid,
	output logic                                o_awready,
	input  logic [wb_bridge_pkg::AXI_AW-1:0]    i_awaddr,
	input  logic [2:0]                          i_awprot,
	// Write data channel
	input  logic                                i_wvalid,
	output logic                                o_wready,
	input  logic [wb_bridge_pkg::DW-1:0]        i_wdata,
	input  logic [wb_bridge_pkg::SW-1:0]        i_wstrb,
	// Write response channel
	output logic                                o_bvalid,
	input  logic                                i_bready,
	output wb_bridge_pkg::axil_resp_e           o_bresp,
	// Read address channel
	input  logic                                i_arvalid,
	output logic                                o_arready,
	input  logic [wb_bridge_pkg::AXI_AW-1:0]    i_araddr,
	input  logic [2:0]                          i_arprot,
	// Read data channel
	output logic                                o_rvalid,
	input  logic                                i_rready,
	output logic [wb_bridge_pkg::DW-1:0]        o_rdata,
	output wb_bridge_pkg::axil_resp_e           o_rresp,
	// Wishbone pipelined master port
	output wb_bridge_pkg::wbp_req_t             o_wb_req,
	input  wb_bridge_pkg::wbp_rsp_t             i_wb_rsp
);
	import wb_bridge_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT,
		ST_BRESP,
		ST_RRESP
	} state_e;

	state_e state;
	logic   wr_take;
	logic   rd_take;
	logic   rsp_done;

	////////////////////////////////////////
	// AXI handshakes
	////////////////////////////////////////
	// Write needs address and data together
	assign wr_take   = (state == ST_IDLE) && i_awvalid && i_wvalid;
	// Read only when no write half is pending
	assign rd_take   = (state == ST_IDLE) && i_arvalid && !i_awvalid && !i_wvalid;
	assign o_awready = wr_take;
	assign o_wready  = wr_take;
	assign o_arready = rd_take;

	// Responses held until the master takes them
	assign o_bvalid = (state == ST_BRESP);
	assign o_rvalid = (state == ST_RRESP);

	// Single ack or err ends the bus cycle
	assign rsp_done = i_wb_rsp.ack || i_wb_rsp.err;

	////////////////////////////////////////
	// Transaction FSM
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state        <= ST_IDLE;
			o_wb_req.cyc <= 1'b0;
			o_wb_req.stb <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (wr_take)
					begin
						o_wb_req.cyc  <= 1'b1;
						o_wb_req.stb  <= 1'b1;
						o_wb_req.we   <= 1'b1;
						o_wb_req.addr <= i_awaddr[AXI_AW-1:2];
						o_wb_req.data <= i_wdata;
						o_wb_req.sel  <= i_wstrb;
						state         <= ST_REQ;
					end
					else if (rd_take)
					begin
						o_wb_req.cyc  <= 1'b1;
						o_wb_req.stb  <= 1'b1;
						o_wb_req.we   <= 1'b0;
						o_wb_req.addr <= i_araddr[AXI_AW-1:2];
						// Reads fetch the whole word
						o_wb_req.sel  <= '1;
						state         <= ST_REQ;
					end
				end
				ST_REQ:
				begin
					// Accepted once stall drops, the ack may come along
					if (!i_wb_rsp.stall)
					begin
						o_wb_req.stb <= 1'b0;
						if (rsp_done)
						begin
							o_wb_req.cyc <= 1'b0;
							state        <= o_wb_req.we ? ST_BRESP : ST_RRESP;
						end
						else
							state <= ST_WAIT;
					end
				end
				ST_WAIT:
				begin
					if (rsp_done)
					begin
						o_wb_req.cyc <= 1'b0;
						state        <= o_wb_req.we ? ST_BRESP : ST_RRESP;
					end
				end
				ST_BRESP:
				begin
					if (i_bready)
						state <= ST_IDLE;
				end
				ST_RRESP:
				begin
					if (i_rready)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Response capture, bus err becomes SLVERR
	always_ff @(posedge i_clk)
	begin
		if (o_wb_req.cyc && rsp_done)
		begin
			if (o_wb_req.we)
				o_bresp <= i_wb_rsp.err ? RESP_SLVERR : RESP_OKAY;
			else
			begin
				o_rresp <= i_wb_rsp.err ? RESP_SLVERR : RESP_OKAY;
				o_rdata <= i_wb_rsp.data;
			end
		end
	end

endmodule

// File: hdl/wbp2classic.sv
/*
 * Wishbone pipelined slave to Wishbone classic master bridge
 * Only one request in flight, the master must not abort a cycle
 * Classic side always signals the classic cycle type
 */
`timescale 1ns/100ps

module wbp2classic (
	input  logic                    i_clk,
	input  logic                    i_reset,
	// Pipelined side
	input  wb_bridge_pkg::wbp_req_t i_mreq,
	output wb_bridge_pkg::wbp_rsp_t o_mrsp,
	// Classic side
	output wb_bridge_pkg::wbc_req_t o_sreq,
	input  wb_bridge_pkg::wbc_rsp_t i_srsp
);
	import wb_bridge_pkg::*;

	// Set once the current request has been answered
	logic          returned;
	logic          mack;
	logic          merr;
	logic [DW-1:0] mdata;

	////////////////////////////////////////
	// Classic request
	////////////////////////////////////////
	always_comb
	begin
		o_sreq.cyc  = i_mreq.cyc;
		// Drop classic stb on the cycle after the slave answers
		o_sreq.stb  = i_mreq.stb && !returned;
		o_sreq.we   = i_mreq.we;
		o_sreq.addr = i_mreq.addr;
		o_sreq.data = i_mreq.data;
		o_sreq.sel  = i_mreq.sel;
		o_sreq.cti  = CTI_CLASSIC;
		// Linear burst, unused for classic cycles
		o_sreq.bte  = 2'b00;
	end

	// Clears again on the accept cycle
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			returned <= 1'b0;
		else if (!i_mreq.stb || returned)
			returned <= 1'b0;
		else if (i_srsp.ack || i_srsp.err)
			returned <= 1'b1;
	end

	////////////////////////////////////////
	// Pipelined response
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			mack <= 1'b0;
			merr <= 1'b0;
		end
		else
		begin
			mack <= i_mreq.cyc && i_srsp.ack;
			merr <= i_mreq.cyc && i_srsp.err;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_srsp.ack || i_srsp.err)
			mdata <= i_srsp.data;
	end

	// Request accepted on the same cycle as the registered ack
	assign o_mrsp = '{stall: !returned, ack: mack, err: merr, data: mdata};

endmodule

// File: hdl/wbc_regfile.sv
/*
 * Wishbone classic slave with 64 word registers and byte enables
 * Answers after a fixed number of wait states
 * Word addresses at or above REG_COUNT get err with zero data and no write
 */
`timescale 1ns/100ps

module wbc_regfile (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  wb_bridge_pkg::wbc_req_t i_req,
	output wb_bridge_pkg::wbc_rsp_t o_rsp
);
	import wb_bridge_pkg::*;

	typedef logic [$clog2(WAIT_STATES+1)-1:0] wait_cnt_t;

	logic [DW-1:0]        regs [REG_COUNT];
	wait_cnt_t            wait_cnt;
	logic                 active;
	logic                 last_wait;
	logic                 in_range;
	logic [REG_IDX_W-1:0] idx;
	logic                 ack;
	logic                 err;
	logic [DW-1:0]        rdata;

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////
	assign active    = i_req.cyc && i_req.stb;
	// Final wait cycle, one answer per strobe
	assign last_wait = active && !ack && !err && (wait_cnt == wait_cnt_t'(WAIT_STATES));
	// Upper address bits must be zero
	assign in_range  = (i_req.addr[WB_AW-1:REG_IDX_W] == '0);
	assign idx       = i_req.addr[REG_IDX_W-1:0];

	// Wait counter restarts whenever stb drops
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !active)
			wait_cnt <= '0;
		else if (!ack && !err && (wait_cnt != wait_cnt_t'(WAIT_STATES)))
			wait_cnt <= wait_cnt + 1'b1;
	end

	////////////////////////////////////////
	// Registers and response
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			ack <= 1'b0;
			err <= 1'b0;
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end
		else
		begin
			// Single cycle pulses
			ack <= last_wait && in_range;
			err <= last_wait && !in_range;
			if (last_wait && in_range && i_req.we)
			begin
				for (int b = 0; b < SW; b++)
				begin
					if (i_req.sel[b])
						regs[idx][8*b +: 8] <= i_req.data[8*b +: 8];
				end
			end
		end
	end

	// Read data valid with ack, zero on err
	always_ff @(posedge i_clk)
	begin
		if (last_wait)
			rdata <= in_range ? regs[idx] : '0;
	end

	assign o_rsp = '{ack: ack, err: err, data: rdata};

endmodule

// File: hdl/axil_wbc_top.sv
/*
 * AXI4-Lite register block built from two bus bridges and a classic slave
 * Register space is 64 words from byte address 0, higher addresses give SLVERR
 */
`timescale 1ns/100ps

module axil_wbc_top (
	input  logic                             i_clk,
	input  logic                             i_reset,
	input  logic                             i_awvalid,
	output logic                             o_awready,
	input  logic [wb_bridge_pkg::AXI_AW-1:0] i_awaddr,
	input  logic [2:0]                       i_awprot,
	input  logic                             i_wvalid,
	output logic                             o_wready,
	input  logic [wb_bridge_pkg::DW-1:0]     i_wdata,
	input  logic [wb_bridge_pkg::SW-1:0]     i_wstrb,
	output logic                             o_bvalid,
	input  logic                             i_bready,
	output wb_bridge_pkg::axil_resp_e        o_bresp,
	input  logic                             i_arvalid,
	output logic                             o_arready,
	input  logic [wb_bridge_pkg::AXI_AW-1:0] i_araddr,
	input  logic [2:0]                       i_arprot,
	output logic                             o_rvalid,
	input  logic                             i_rready,
	output logic [wb_bridge_pkg::DW-1:0]     o_rdata,
	output wb_bridge_pkg::axil_resp_e        o_rresp
);
	import wb_bridge_pkg::*;

	// Links along the bridge chain
	wbp_req_t wbp_req;
	wbp_rsp_t wbp_rsp;
	wbc_req_t wbc_req;
	wbc_rsp_t wbc_rsp;

	////////////////////////////////////////
	// AXI4-Lite to pipelined Wishbone
	////////////////////////////////////////
	axil2wbp u_axil2wbp (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_awvalid (i_awvalid),
		.o_awready (o_awready),
		.i_awaddr  (i_awaddr),
		.i_awprot  (i_awprot),
		.i_wvalid  (i_wvalid),
		.o_wready  (o_wready),
		.i_wdata   (i_wdata),
		.i_wstrb   (i_wstrb),
		.o_bvalid  (o_bvalid),
		.i_bready  (i_bready),
		.o_bresp   (o_bresp),
		.i_arvalid (i_arvalid),
		.o_arready (o_arready),
		.i_araddr  (i_araddr),
		.i_arprot  (i_arprot),
		.o_rvalid  (o_rvalid),
		.i_rready  (i_rready),
		.o_rdata   (o_rdata),
		.o_rresp   (o_rresp),
		.o_wb_req  (wbp_req),
		.i_wb_rsp  (wbp_rsp)
	);

	// Pipelined to classic
	wbp2classic u_wbp2classic (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_mreq  (wbp_req),
		.o_mrsp  (wbp_rsp),
		.o_sreq  (wbc_req),
		.i_srsp  (wbc_rsp)
	);

	// Register block at the end of the chain
	wbc_regfile u_regfile (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_req   (wbc_req),
		.o_rsp   (wbc_rsp)
	);

endmodule

// File: verif/tb_axil_wbc_top.sv
/*
 * Table driven testbench for the AXI4-Lite register block
 * Expected values come from a shadow register model built along with the table
 * Inputs change 2 ns after the rising edge
 * Outputs are sampled on the falling edge
 */
`timescale 1ns/100ps

module tb_axil_wbc_top;
	import wb_bridge_pkg::*;

	localparam int          CLK_PERIOD = 40;
	localparam int          DRIVE_DLY  = 2;
	localparam int          TABLE_SIZE = 128;
	localparam int          WD_CYCLES  = 40;
	localparam logic [31:0] SEED       = 32'h8a1d_07bf;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WR_RD} op_e;

	// One stimulus line with its expected answer
	typedef struct packed {
		op_e               op;
		logic [AXI_AW-1:0] addr;
		logic [DW-1:0]     data;
		logic [SW-1:0]     strb;
		logic [3:0]        hold;
		axil_resp_e        exp_resp;
		logic [DW-1:0]     exp_data;
	} entry_t;

	logic i_clk, i_reset;
	logic i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
	logic [AXI_AW-1:0] i_awaddr, i_araddr;
	logic [2:0] i_awprot, i_arprot;
	logic [DW-1:0] i_wdata, o_rdata;
	logic [SW-1:0] i_wstrb;
	logic o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
	axil_resp_e o_bresp, o_rresp;

	entry_t        tbl [TABLE_SIZE];
	logic [DW-1:0] shadow [REG_COUNT];
	int            n_entries;
	int            cur_entry;
	int            error_count;
	bit            table_ready;

	axil_wbc_top i_dut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// Reference model and table
	////////////////////////////////////////
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte-enable write that leaves unmapped words alone
	task automatic model_write(input logic [AXI_AW-1:0] addr, input logic [DW-1:0] data,
			input logic [SW-1:0] strb, output axil_resp_e resp);
		int idx;
		idx  = int'(addr[AXI_AW-1:2]);
		resp = (idx < REG_COUNT) ? RESP_OKAY : RESP_SLVERR;
		for (int b = 0; b < SW; b++)
		begin
			if (idx < REG_COUNT && strb[b])
				shadow[idx][8*b +: 8] = data[8*b +: 8];
		end
	endtask

	task automatic model_read(input logic [AXI_AW-1:0] addr, output logic [DW-1:0] data,
			output axil_resp_e resp);
		int idx;
		idx  = int'(addr[AXI_AW-1:2]);
		resp = (idx < REG_COUNT) ? RESP_OKAY : RESP_SLVERR;
		data = (idx < REG_COUNT) ? shadow[idx] : '0;
	endtask

	task automatic add_write(input logic [AXI_AW-1:0] a, input logic [DW-1:0] d,
			input logic [SW-1:0] s, input logic [3:0] hold);
		entry_t t;
		t = '{op: OP_WRITE, addr: a, data: d, strb: s, hold: hold, exp_resp: RESP_OKAY,
			exp_data: '0};
		model_write(a, d, s, t.exp_resp);
		tbl[n_entries++] = t;
	endtask

	task automatic add_read(input logic [AXI_AW-1:0] a, input logic [3:0] hold);
		entry_t t;
		t = '{op: OP_READ, addr: a, data: '0, strb: '0, hold: hold, exp_resp: RESP_OKAY,
			exp_data: '0};
		model_read(a, t.exp_data, t.exp_resp);
		tbl[n_entries++] = t;
	endtask

	// Write and read raised together so the read sees the new value
	task automatic add_both(input logic [AXI_AW-1:0] a, input logic [DW-1:0] d,
			input logic [SW-1:0] s, input logic [3:0] hold);
		entry_t t;
		t = '{op: OP_WR_RD, addr: a, data: d, strb: s, hold: hold, exp_resp: RESP_OKAY,
			exp_data: '0};
		model_write(a, d, s, t.exp_resp);
		model_read(a, t.exp_data, t.exp_resp);
		tbl[n_entries++] = t;
	endtask

	task automatic build_table();
		logic [31:0]       rnd;
		logic [AXI_AW-1:0] a;
		rnd       = SEED;
		n_entries = 0;
		for (int i = 0; i < REG_COUNT; i++)
			shadow[i] = '0;
		// Reset values
		add_read(12'h000, 0);
		add_read(12'h004, 0);
		add_read(12'h080, 0);
		add_read(12'h0fc, 0);
		// Full words
		for (int i = 0; i < 3; i++)
		begin
			rnd    = lcg_step(rnd);
			a      = '0;
			a[7:2] = rnd[21:16];
			rnd    = lcg_step(rnd);
			add_write(a, rnd, 4'hf, 0);
			add_read(a, 0);
		end
		// Random strobes on a few registers so bytes merge
		for (int i = 0; i < 12; i++)
		begin
			rnd    = lcg_step(rnd);
			a      = '0;
			a[4:2] = rnd[18:16];
			rnd    = lcg_step(rnd);
			add_write(a, rnd, rnd[27:24] ^ rnd[11:8], 0);
			add_read(a, 0);
		end
		// Unmapped space and a read-back of the whole block
		rnd = lcg_step(rnd);
		add_write(12'h100, rnd, 4'hf, 0);
		add_write(12'hffc, ~rnd, 4'hf, 0);
		add_write(12'h400, rnd, 4'h3, 0);
		add_read(12'h100, 0);
		add_read(12'hffc, 0);
		for (int i = 0; i < REG_COUNT; i++)
			add_read(AXI_AW'(i * 4), 0);
		// Back-pressure on B and R
		rnd = lcg_step(rnd);
		add_write(12'h020, rnd, 4'hf, 5);
		add_read(12'h020, 6);
		rnd = lcg_step(rnd);
		add_write(12'h024, rnd, 4'hf, 0);
		add_read(12'h024, 3);
		// Simultaneous write and read
		rnd = lcg_step(rnd);
		add_both(12'h030, rnd, 4'hf, 0);
		add_both(12'h034, ~rnd, 4'h5, 2);
	endtask

	////////////////////////////////////////
	// Bus driving
	////////////////////////////////////////
	task automatic next_drive_point();
		@(posedge i_clk);
		#DRIVE_DLY;
	endtask

	// Valids and payload of an entry, held until its own handshake
	task automatic raise_request(input entry_t t);
		if (t.op != OP_READ)
		begin
			i_awvalid = 1'b1;
			i_awaddr  = t.addr;
			i_wvalid  = 1'b1;
			i_wdata   = t.data;
			i_wstrb   = t.strb;
		end
		if (t.op != OP_WRITE)
		begin
			i_arvalid = 1'b1;
			i_araddr  = t.addr;
		end
	endtask

	// Next request waits behind a held response
	task automatic queue_next(input int e);
		if (tbl[e].hold != 0 && e + 1 < n_entries)
			raise_request(tbl[e + 1]);
	endtask

	task automatic send_write(input entry_t t);
		raise_request(t);
		@(negedge i_clk);
		while (!(o_awready && o_wready))
			@(negedge i_clk);
		// Writes win over a read in the same cycle
		assert (!o_arready)
		else
		begin
			$display("Read accepted together with a write in entry %0d", cur_entry);
			error_count++;
		end
		next_drive_point();
		i_awvalid = 1'b0;
		i_wvalid  = 1'b0;
	endtask

	task automatic send_read(input logic [AXI_AW-1:0] addr);
		i_arvalid = 1'b1;
		i_araddr  = addr;
		@(negedge i_clk);
		while (!o_arready)
			@(negedge i_clk);
		next_drive_point();
		i_arvalid = 1'b0;
	endtask

	// Holds bready low for hold cycles once bvalid shows
	task automatic take_bresp(input int hold, output axil_resp_e resp);
		i_bready = (hold == 0);
		@(negedge i_clk);
		while (!o_bvalid)
			@(negedge i_clk);
		resp = o_bresp;
		for (int h = 0; h < hold; h++)
		begin
			next_drive_point();
			i_bready = (h == hold - 1);
			@(negedge i_clk);
			assert (o_bvalid && o_bresp == resp &&
				!o_awready && !o_wready && !o_arready)
			else
			begin
				$display("Write response not held or new request taken, entry %0d", cur_entry);
				error_count++;
			end
		end
		next_drive_point();
	endtask

	task automatic take_rresp(input int hold, output logic [DW-1:0] data,
			output axil_resp_e resp);
		i_rready = (hold == 0);
		@(negedge i_clk);
		while (!o_rvalid)
			@(negedge i_clk);
		resp = o_rresp;
		data = o_rdata;
		for (int h = 0; h < hold; h++)
		begin
			next_drive_point();
			i_rready = (h == hold - 1);
			@(negedge i_clk);
			assert (o_rvalid && o_rresp == resp && o_rdata == data &&
				!o_awready && !o_wready && !o_arready)
			else
			begin
				$display("Read response not held or new request taken, entry %0d", cur_entry);
				error_count++;
			end
		end
		next_drive_point();
	endtask

	////////////////////////////////////////
	// Checking
	////////////////////////////////////////
	task automatic check_value(input string what, input logic [DW-1:0] exp,
			input logic [DW-1:0] act);
		assert (act === exp)
		else
		begin
			$display("ERROR t=%0t entry %0d: %s expected 0x%08h got 0x%08h",
				$time, cur_entry, what, exp, act);
			error_count++;
		end
	endtask

	task automatic run_entry(input int e);
		entry_t        t;
		axil_resp_e    resp;
		logic [DW-1:0] rdata;
		t = tbl[e];
		if (t.op != OP_READ)
		begin
			send_write(t);
			// A combined entry already has its own read waiting
			if (t.op == OP_WRITE)
				queue_next(e);
			take_bresp(t.hold, resp);
			check_value("bresp", DW'(t.exp_resp), DW'(resp));
		end
		if (t.op != OP_WRITE)
		begin
			send_read(t.addr);
			queue_next(e);
			take_rresp(t.hold, rdata, resp);
			check_value("rresp", DW'(t.exp_resp), DW'(resp));
			check_value("rdata", t.exp_data, rdata);
		end
	endtask

	initial
	begin
		int errs_before;
		int passed;
		i_reset   = 1'b1;
		i_awvalid = 1'b0;
		i_awaddr  = '0;
		i_awprot  = 3'b010;
		i_wvalid  = 1'b0;
		i_wdata   = '0;
		i_wstrb   = '0;
		i_bready  = 1'b1;
		i_arvalid = 1'b0;
		i_araddr  = '0;
		i_arprot  = 3'b010;
		i_rready  = 1'b1;
		error_count = 0;
		passed      = 0;
		cur_entry   = 0;
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge i_clk);
		#DRIVE_DLY;
		i_reset = 1'b0;
		for (int e = 0; e < n_entries; e++)
		begin
			cur_entry   = e;
			errs_before = error_count;
			run_entry(e);
			if (error_count == errs_before)
				passed++;
			$display("entry %0d %s addr 0x%03h hold %0d: %s", e, tbl[e].op.name(),
				tbl[e].addr, tbl[e].hold, (error_count == errs_before) ? "pass" : "fail");
		end
		$display("Entries %0d, passed %0d, failed %0d, check errors %0d",
			n_entries, passed, n_entries - passed, error_count);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Bound of WD_CYCLES per entry plus reset
	initial
	begin
		wait (table_ready);
		#((n_entries * WD_CYCLES + 4) * CLK_PERIOD);
		$display("Timeout: entry %0d never finished its handshakes", cur_entry);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: Bender.yml
package:
  name: axil_wbc

# AXI4-Lite register block behind an AXI4-Lite to Wishbone bridge chain
sources:
  # Shared sizes, structs and encodings first
  - hdl/wb_bridge_pkg.sv
  # Bridges and register slave
  - hdl/axil2wbp.sv
  - hdl/wbp2classic.sv
  - hdl/wbc_regfile.sv
  # Top level
  - hdl/axil_wbc_top.sv

  # Self-checking testbench
  - target: test
    files:
      - verif/tb_axil_wbc_top.sv

// File: src.f
hdl/wb_bridge_pkg.sv
hdl/axil2wbp.sv
hdl/wbp2classic.sv
hdl/wbc_regfile.sv
hdl/axil_wbc_top.sv
verif/tb_axil_wbc_top.sv
